//--- design/reg_map_pkg.sv
package reg_map_pkg;

  // byte index within a multi-byte register
  localparam int bytecnt_size = 7;

  // number of bytes in the 32 bit registers
  localparam int multi_byte_regs = 4;

  // register addresses on the usb register bus
  localparam logic [7:0] adcread_addr = 8'd3;          // fifo data, one byte per read
  localparam logic [7:0] adc_low_res_addr = 8'd5;      // bit 0 low_res, bit 1 low_res_lsb

  // read gives empty and errors, any write clears the errors
  localparam logic [7:0] fifo_stat_addr = 8'd11;

  localparam logic [7:0] stream_segment_size_addr = 8'd14;  // 32 bit, byte per bytecnt
  localparam logic [7:0] fast_fifo_read_mode_addr = 8'd15;  // bit 0

  // debug counters, read only
  localparam logic [7:0] debug_fifo_reads_addr = 8'd20;
  localparam logic [7:0] debug_fifo_reads_freeze_addr = 8'd21;

  // reset value of the segment size register
  localparam logic [31:0] segment_size_default = 32'd32;

endpackage

//--- design/adc_sample_pkg.sv
package adc_sample_pkg;

  localparam int sample_width = 10;  // adc resolution
  localparam int fifo_word_width = 16;

  // fifo word as seen by the packer and the byte readout
  // full view holds one sample right aligned
  // low view holds two 8 bit samples, first one in the low byte
  typedef union packed {
    struct packed {
      logic [fifo_word_width-sample_width-1:0] pad;  // always zero
      logic [sample_width-1:0] sample;
    } full;
    struct packed {
      logic [7:0] second;  // read out last
      logic [7:0] first;   // read out first
    } low;
  } fifo_word_t;

  localparam int fifo_depth_words = 16;
  localparam int fifo_addr_width = 4;  // log2 of the depth

  // error status layout
  localparam int err_stat_width = 7;
  localparam int err_overflow_bit = 0;   // word dropped while full
  localparam int err_underflow_bit = 1;  // pop while empty
  localparam int err_drop_cnt_lsb = 2;
  localparam int err_drop_cnt_width = 5;  // saturating

endpackage

//--- design/adc_sample_packer.sv
`timescale 1ns/1ps

module adc_sample_packer
  import adc_sample_pkg::*;
(
  input  logic                    clk_usb,
  input  logic                    reset,
  input  logic [sample_width-1:0] adc_sample,
  input  logic                    adc_sample_valid,
  input  logic                    low_res,
  input  logic                    low_res_lsb,
  output fifo_word_t              fifo_wr_word,
  output logic                    fifo_wr_en
);

  logic       low_res_r;     // mode seen on previous cycle
  logic       mode_change;
  logic       pending_valid; // first half of a pair is held
  logic       have_pending;
  logic [7:0] pending_byte;
  logic [7:0] sample_byte;

  // upper 8 bits by default, lower 8 when lsb selected
  assign sample_byte = low_res_lsb ? adc_sample[7:0] : adc_sample[sample_width-1:2];

  // half pair from the old mode is never used
  assign mode_change = low_res != low_res_r;
  assign have_pending = pending_valid & ~mode_change;

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res_r <= 1'b0;
      pending_valid <= 1'b0;
      fifo_wr_en <= 1'b0;
    end else begin
      low_res_r <= low_res;
      fifo_wr_en <= 1'b0;  // strobe by default
      if (mode_change)
        pending_valid <= 1'b0;  // drop the stale half
      if (adc_sample_valid) begin
        if (!low_res) begin
          fifo_wr_en <= 1'b1;  // one sample per word
        end else if (have_pending) begin
          fifo_wr_en <= 1'b1;  // pair complete
          pending_valid <= 1'b0;
        end else begin
          pending_valid <= 1'b1;
        end
      end
    end
  end

  // payload path
  always_ff @(posedge clk_usb) begin
    if (adc_sample_valid) begin
      if (!low_res) begin
        fifo_wr_word.full.pad <= '0;
        fifo_wr_word.full.sample <= adc_sample;
      end else if (have_pending) begin
        fifo_wr_word.low.first <= pending_byte;
        fifo_wr_word.low.second <= sample_byte;
      end else begin
        pending_byte <= sample_byte;  // wait for partner
      end
    end
  end

endmodule

//--- design/adc_word_fifo.sv
`timescale 1ns/1ps

module adc_word_fifo
  import adc_sample_pkg::*;
(
  input  logic                      clk_usb,
  input  logic                      reset,
  input  fifo_word_t                wr_word,
  input  logic                      wr_en,
  input  logic                      rd_en,
  input  logic                      clear_errors,
  output logic [7:0]                data,
  output logic                      empty,
  output logic [err_stat_width-1:0] error_stat,
  output logic [31:0]               read_count,
  output logic [31:0]               read_count_error_freeze
);

  fifo_word_t mem [fifo_depth_words];

  logic [fifo_addr_width-1:0] wr_ptr;
  logic [fifo_addr_width-1:0] rd_ptr;
  logic [fifo_addr_width:0]   count;       // words held, 0 to depth
  logic                       byte_phase;  // high byte next when set
  logic                       full;
  logic                       wr_accept;
  logic                       wr_drop;
  logic                       rd_accept;
  logic                       rd_under;
  logic                       word_done;
  logic                       err_event;
  logic                       overflow;
  logic                       underflow;
  logic [err_drop_cnt_width-1:0] drop_cnt;
  logic                       frozen;      // freeze value captured since clear
  fifo_word_t                 head;

  assign full = count == fifo_depth_words;
  assign empty = count == '0;

  assign wr_accept = wr_en & ~full;
  assign wr_drop = wr_en & full;    // no back-pressure, word lost
  assign rd_accept = rd_en & ~empty;
  assign rd_under = rd_en & empty;
  assign word_done = rd_accept & byte_phase;  // word freed after high byte
  assign err_event = wr_drop | rd_under;

  // show-ahead read, byte view of the head word
  assign head = mem[rd_ptr];
  assign data = empty ? 8'h00 : (byte_phase ? head.low.second : head.low.first);

  assign error_stat = {drop_cnt, underflow, overflow};

  always_ff @(posedge clk_usb) begin
    if (wr_accept)
      mem[wr_ptr] <= wr_word;
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      byte_phase <= 1'b0;
    end else begin
      if (wr_accept)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (rd_accept)
        byte_phase <= ~byte_phase;
      if (word_done)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_accept, word_done})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  // sticky error flags
  always_ff @(posedge clk_usb) begin
    if (reset || clear_errors) begin
      overflow <= 1'b0;
      underflow <= 1'b0;
      drop_cnt <= '0;
    end else begin
      if (wr_drop) begin
        overflow <= 1'b1;
        if (drop_cnt != '1)
          drop_cnt <= drop_cnt + 1'b1;  // saturates
      end
      if (rd_under)
        underflow <= 1'b1;
    end
  end

  // debug counters
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      read_count <= '0;
      read_count_error_freeze <= '0;
      frozen <= 1'b0;
    end else begin
      if (rd_accept)
        read_count <= read_count + 1'b1;  // accepted byte pops only
      if (clear_errors) begin
        frozen <= 1'b0;  // rearm, old value kept
      end else if (err_event && !frozen) begin
        read_count_error_freeze <= read_count;  // pops before the first error
        frozen <= 1'b1;
      end
    end
  end

endmodule

//--- design/reg_adcfifo.sv
`timescale 1ns/1ps

module reg_adcfifo
  import reg_map_pkg::*;
  import adc_sample_pkg::*;
(
  input  logic                      clk_usb,
  input  logic                      reset,
  input  logic [7:0]                reg_address,
  input  logic [bytecnt_size-1:0]   reg_bytecnt,
  input  logic [7:0]                reg_datai,
  output logic [7:0]                reg_datao,
  input  logic                      reg_read,
  input  logic                      reg_write,
  input  logic                      fifo_empty,
  input  logic [7:0]                fifo_data,
  output logic                      fifo_rd_en,
  output logic                      low_res,
  output logic                      low_res_lsb,
  output logic                      fast_fifo_read_mode,
  output logic [31:0]               stream_segment_size,
  input  logic [err_stat_width-1:0] fifo_error_stat,
  output logic                      clear_fifo_errors,
  input  logic [31:0]               fifo_read_count,
  input  logic [31:0]               fifo_read_count_error_freeze
);

  logic       byte_in_range;  // bytecnt within a 32 bit register
  logic [1:0] byte_sel;
  logic [4:0] byte_base;      // bit offset of the selected byte
  logic       reg_read_r;
  logic       read_edge;      // rising reg_read at the fifo address
  logic       pop_delayed;

  assign byte_in_range = reg_bytecnt < multi_byte_regs;
  assign byte_sel = reg_bytecnt[1:0];
  assign byte_base = {byte_sel, 3'b000};

  assign read_edge = reg_read & ~reg_read_r & (reg_address == adcread_addr);

  // fast mode pops on the edge itself, normal mode one cycle later
  assign fifo_rd_en = fast_fifo_read_mode ? read_edge : pop_delayed;

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_read_r <= 1'b0;
      pop_delayed <= 1'b0;
    end else begin
      reg_read_r <= reg_read;
      pop_delayed <= read_edge & ~fast_fifo_read_mode;  // no double pop in fast mode
    end
  end

  // read mux
  always_comb begin
    reg_datao = 8'h00;
    if (fast_fifo_read_mode) begin
      reg_datao = fifo_data;  // data ready before the read strobe
    end else if (reg_read) begin
      case (reg_address)
        adcread_addr:
          reg_datao = fifo_data;
        adc_low_res_addr:
          reg_datao = {6'b0, low_res_lsb, low_res};
        fifo_stat_addr:
          reg_datao = {fifo_empty, fifo_error_stat};  // empty on top
        stream_segment_size_addr:
          if (byte_in_range)
            reg_datao = stream_segment_size[byte_base +: 8];
        debug_fifo_reads_addr:
          if (byte_in_range)
            reg_datao = fifo_read_count[byte_base +: 8];
        debug_fifo_reads_freeze_addr:
          if (byte_in_range)
            reg_datao = fifo_read_count_error_freeze[byte_base +: 8];
        default: ;  // unmapped reads give zero
      endcase
    end
  end

  // register writes
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res <= 1'b0;
      low_res_lsb <= 1'b0;
      fast_fifo_read_mode <= 1'b0;
      stream_segment_size <= segment_size_default;
      clear_fifo_errors <= 1'b0;
    end else begin
      // single cycle pulse after a status write
      clear_fifo_errors <= reg_write && (reg_address == fifo_stat_addr);
      if (reg_write) begin
        if (reg_address != fast_fifo_read_mode_addr)
          fast_fifo_read_mode <= 1'b0;  // any other write leaves fast mode
        case (reg_address)
          adc_low_res_addr: begin
            low_res <= reg_datai[0];
            low_res_lsb <= reg_datai[1];
          end
          stream_segment_size_addr:
            if (byte_in_range)
              stream_segment_size[byte_base +: 8] <= reg_datai;
          fast_fifo_read_mode_addr:
            fast_fifo_read_mode <= reg_datai[0];
          default: ;
        endcase
      end
    end
  end

endmodule

//--- design/adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top
  import reg_map_pkg::*;
  import adc_sample_pkg::*;
(
  input  logic                    clk_usb,
  input  logic                    reset,
  input  logic [7:0]              reg_address,
  input  logic [bytecnt_size-1:0] reg_bytecnt,
  input  logic [7:0]              reg_datai,
  output logic [7:0]              reg_datao,
  input  logic                    reg_read,
  input  logic                    reg_write,
  input  logic [sample_width-1:0] adc_sample,
  input  logic                    adc_sample_valid,
  output logic [31:0]             stream_segment_size
);

  fifo_word_t                fifo_wr_word;
  logic                      fifo_wr_en;
  logic                      low_res;
  logic                      low_res_lsb;
  logic                      fast_fifo_read_mode;  // stays internal
  logic                      fifo_rd_en;
  logic                      clear_fifo_errors;
  logic [7:0]                fifo_data;
  logic                      fifo_empty;
  logic [err_stat_width-1:0] fifo_error_stat;
  logic [31:0]               fifo_read_count;
  logic [31:0]               fifo_read_count_error_freeze;

  adc_sample_packer u_packer (
    .clk_usb          (clk_usb),
    .reset            (reset),
    .adc_sample       (adc_sample),
    .adc_sample_valid (adc_sample_valid),
    .low_res          (low_res),
    .low_res_lsb      (low_res_lsb),
    .fifo_wr_word     (fifo_wr_word),
    .fifo_wr_en       (fifo_wr_en)
  );

  adc_word_fifo u_fifo (
    .clk_usb                 (clk_usb),
    .reset                   (reset),
    .wr_word                 (fifo_wr_word),
    .wr_en                   (fifo_wr_en),
    .rd_en                   (fifo_rd_en),
    .clear_errors            (clear_fifo_errors),
    .data                    (fifo_data),
    .empty                   (fifo_empty),
    .error_stat              (fifo_error_stat),
    .read_count              (fifo_read_count),
    .read_count_error_freeze (fifo_read_count_error_freeze)
  );

  reg_adcfifo u_regs (
    .clk_usb                      (clk_usb),
    .reset                        (reset),
    .reg_address                  (reg_address),
    .reg_bytecnt                  (reg_bytecnt),
    .reg_datai                    (reg_datai),
    .reg_datao                    (reg_datao),
    .reg_read                     (reg_read),
    .reg_write                    (reg_write),
    .fifo_empty                   (fifo_empty),
    .fifo_data                    (fifo_data),
    .fifo_rd_en                   (fifo_rd_en),
    .low_res                      (low_res),
    .low_res_lsb                  (low_res_lsb),
    .fast_fifo_read_mode          (fast_fifo_read_mode),
    .stream_segment_size          (stream_segment_size),
    .fifo_error_stat              (fifo_error_stat),
    .clear_fifo_errors            (clear_fifo_errors),
    .fifo_read_count              (fifo_read_count),
    .fifo_read_count_error_freeze (fifo_read_count_error_freeze)
  );

endmodule

//--- sim/adc_capture_assertions.sv
`timescale 1ns/1ps

module adc_capture_assertions
  import reg_map_pkg::*;
(
  input logic       clk_usb,
  input logic       reset,
  input logic [7:0] reg_address,
  input logic       reg_read,
  input logic       reg_write,
  input logic       fifo_rd_en,
  input logic       clear_fifo_errors,
  input logic       fast_fifo_read_mode
);

  int fail_count = 0;  // assertion failures so far

  logic fifo_read;  // read strobe at the fifo data address
  assign fifo_read = reg_read && (reg_address == adcread_addr);

  // clear pulse is one cycle wide and comes right after a status write
  clear_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
    clear_fifo_errors |-> $past(reg_write && (reg_address == fifo_stat_addr))
      ##1 !clear_fifo_errors)
    else begin
      fail_count++;
      $error("clear_fifo_errors not a single pulse after a status write");
    end

  // pop only during or just after a fifo data read
  pop_from_read: assert property (@(posedge clk_usb) disable iff (reset)
    $rose(fifo_rd_en) |-> fifo_read || $past(fifo_read))
    else begin
      fail_count++;
      $error("fifo_rd_en rose outside a fifo data read");
    end

  // fast mode pops on the read edge itself and on no other cycle
  fast_pop_on_edge: assert property (@(posedge clk_usb) disable iff (reset)
    fast_fifo_read_mode |-> fifo_rd_en == (fifo_read && $rose(reg_read)))
    else begin
      fail_count++;
      $error("fast mode pop not aligned with the read edge");
    end

endmodule

bind reg_adcfifo adc_capture_assertions u_assertions (
  .clk_usb             (clk_usb),
  .reset               (reset),
  .reg_address         (reg_address),
  .reg_read            (reg_read),
  .reg_write           (reg_write),
  .fifo_rd_en          (fifo_rd_en),
  .clear_fifo_errors   (clear_fifo_errors),
  .fast_fifo_read_mode (fast_fifo_read_mode)
);

//--- sim/tb_adc_capture.sv
`timescale 1ns/1ps

module tb_adc_capture
  import reg_map_pkg::*;
  import adc_sample_pkg::*;
();

  localparam int max_steps = 160;
  localparam logic [1:0] op_write = 2'd0, op_read = 2'd1, op_burst = 2'd2, op_idle = 2'd3;
  localparam logic [1:0] cmp_none = 2'd0, cmp_lit = 2'd1, cmp_model = 2'd2;

  typedef struct packed {
    logic [1:0]              op;
    logic [7:0]              addr;
    logic [bytecnt_size-1:0] bytecnt;
    logic [31:0]             data;      // write data or burst length
    logic [31:0]             expected;  // used with cmp_lit
    logic [1:0]              cmp;
  } step_t;

  logic                    clk_usb = 1'b0;
  logic                    reset;
  logic [7:0]              reg_address;
  logic [bytecnt_size-1:0] reg_bytecnt;
  logic [7:0]              reg_datai;
  logic                    reg_read;
  logic                    reg_write;
  logic [sample_width-1:0] adc_sample;
  logic                    adc_sample_valid;
  wire  [7:0]              reg_datao;
  wire  [31:0]             stream_segment_size;

  step_t       steps [max_steps];
  int          n_steps = 0;
  int          errors = 0;
  logic        table_ready = 1'b0;
  logic [31:0] lfsr = 32'h28ff;

  // reference model of packer and fifo
  logic [15:0] m_words [$];
  logic        m_phase = 1'b0;  // high byte next
  logic        m_low_res = 1'b0, m_lsb = 1'b0, m_fast = 1'b0;
  logic        m_pending_valid = 1'b0;
  logic [7:0]  m_pending;
  logic        m_over = 1'b0, m_under = 1'b0, m_frozen = 1'b0;
  logic [4:0]  m_drops = '0;
  logic [31:0] m_seg = segment_size_default;
  logic [31:0] m_reads = '0, m_freeze = '0;

  adc_capture_top u_dut (.*);

  always #5 clk_usb = ~clk_usb;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_sample(output logic [sample_width-1:0] s);
    s = '0;
    for (int b = 0; b < sample_width; b++) begin
      lfsr = next_lfsr(lfsr);  // one step per bit
      s = {s[sample_width-2:0], lfsr[0]};
    end
  endtask

  task automatic note_error();
    if (!m_frozen) begin
      m_freeze = m_reads;  // pops before the first error
      m_frozen = 1'b1;
    end
  endtask

  task automatic push_word(input logic [15:0] w);
    if (m_words.size() < fifo_depth_words) begin
      m_words.push_back(w);
    end else begin
      m_over = 1'b1;  // dropped while full
      if (m_drops != 5'h1f)
        m_drops++;
      note_error();
    end
  endtask

  task automatic pack_sample(input logic [sample_width-1:0] s);
    logic [7:0] b;
    b = m_lsb ? s[7:0] : s[9:2];
    if (!m_low_res) begin
      push_word({6'b0, s});
    end else if (m_pending_valid) begin
      push_word({b, m_pending});  // first sample in low byte
      m_pending_valid = 1'b0;
    end else begin
      m_pending = b;
      m_pending_valid = 1'b1;
    end
  endtask

  task automatic predict_write(input logic [7:0] addr, input int bc, input logic [7:0] d);
    if (addr != fast_fifo_read_mode_addr)
      m_fast = 1'b0;
    case (addr)
      adc_low_res_addr: begin
        if (d[0] != m_low_res)
          m_pending_valid = 1'b0;  // half pair lost on mode change
        m_low_res = d[0];
        m_lsb = d[1];
      end
      fifo_stat_addr: begin
        {m_over, m_under, m_drops, m_frozen} = '0;
      end
      stream_segment_size_addr:
        if (bc < 4)
          m_seg[bc*8 +: 8] = d;
      fast_fifo_read_mode_addr:
        m_fast = d[0];
      default: ;
    endcase
  endtask

  function automatic logic [7:0] head_byte();
    if (m_words.size() == 0)
      return 8'h00;
    return m_phase ? m_words[0][15:8] : m_words[0][7:0];
  endfunction

  task automatic predict_read(input logic [7:0] addr, input int bc, output logic [7:0] v);
    v = 8'h00;
    if (m_fast) begin
      v = head_byte();  // fast mode shows fifo data at any address
    end else begin
      case (addr)
        adcread_addr: v = head_byte();
        adc_low_res_addr: v = {6'b0, m_lsb, m_low_res};
        fifo_stat_addr: v = {m_words.size() == 0, m_drops, m_under, m_over};
        stream_segment_size_addr: if (bc < 4) v = m_seg[bc*8 +: 8];
        debug_fifo_reads_addr: if (bc < 4) v = m_reads[bc*8 +: 8];
        debug_fifo_reads_freeze_addr: if (bc < 4) v = m_freeze[bc*8 +: 8];
        default: ;
      endcase
    end
    if (addr == adcread_addr) begin
      if (m_words.size() == 0) begin
        m_under = 1'b1;
        note_error();
      end else begin
        m_reads++;
        if (m_phase)
          void'(m_words.pop_front());  // freed after high byte
        m_phase = !m_phase;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic add_step(input logic [1:0] op, input logic [7:0] addr, input int bc,
                          input logic [31:0] data, input logic [31:0] exp, input logic [1:0] cmp);
    steps[n_steps] = {op, addr, bc[bytecnt_size-1:0], data, exp, cmp};
    n_steps++;
  endtask

  task automatic read_steps(input logic [7:0] addr, input int bc, input int n);
    repeat (n)
      add_step(op_read, addr, bc, 0, 0, cmp_model);
  endtask

  task automatic build_table();
    add_step(op_idle, 0, 0, 0, segment_size_default, cmp_lit);  // reset defaults
    add_step(op_read, fifo_stat_addr, 0, 0, 32'h80, cmp_lit);
    for (int b = 0; b < 4; b++)
      add_step(op_write, stream_segment_size_addr, b, 8'h78 - 8'h22 * b, 0, cmp_none);
    add_step(op_idle, 0, 0, 0, 32'h12345678, cmp_lit);
    read_steps(stream_segment_size_addr, 2, 1);
    add_step(op_burst, 0, 0, 5, 0, cmp_none);  // full resolution
    read_steps(adcread_addr, 0, 10);
    add_step(op_read, fifo_stat_addr, 0, 0, 32'h80, cmp_lit);
    add_step(op_write, adc_low_res_addr, 0, 1, 0, cmp_none);  // low res, top bits
    add_step(op_burst, 0, 0, 6, 0, cmp_none);
    read_steps(adcread_addr, 0, 6);
    add_step(op_write, adc_low_res_addr, 0, 3, 0, cmp_none);  // low res, bottom bits
    add_step(op_burst, 0, 0, 4, 0, cmp_none);
    read_steps(adcread_addr, 0, 4);
    add_step(op_burst, 0, 0, 3, 0, cmp_none);  // leaves half a pair
    add_step(op_write, adc_low_res_addr, 0, 0, 0, cmp_none);
    add_step(op_write, adc_low_res_addr, 0, 1, 0, cmp_none);
    add_step(op_burst, 0, 0, 2, 0, cmp_none);
    read_steps(adcread_addr, 0, 4);
    read_steps(fifo_stat_addr, 0, 1);
    add_step(op_write, adc_low_res_addr, 0, 0, 0, cmp_none);
    add_step(op_burst, 0, 0, 20, 0, cmp_none);  // four words over depth
    read_steps(fifo_stat_addr, 0, 1);
    for (int b = 0; b < 4; b++)
      read_steps(debug_fifo_reads_freeze_addr, b, 1);
    read_steps(adcread_addr, 0, 33);  // last one underflows
    read_steps(fifo_stat_addr, 0, 1);
    read_steps(debug_fifo_reads_addr, 0, 1);
    read_steps(debug_fifo_reads_addr, 1, 1);
    add_step(op_write, fifo_stat_addr, 0, 0, 0, cmp_none);
    add_step(op_read, fifo_stat_addr, 0, 0, 32'h80, cmp_lit);
    read_steps(adcread_addr, 0, 1);
    read_steps(debug_fifo_reads_freeze_addr, 0, 1);
    read_steps(debug_fifo_reads_freeze_addr, 1, 1);
    add_step(op_write, fifo_stat_addr, 0, 0, 0, cmp_none);
    add_step(op_burst, 0, 0, 2, 0, cmp_none);  // fast read mode
    add_step(op_write, fast_fifo_read_mode_addr, 0, 1, 0, cmp_none);
    read_steps(adcread_addr, 0, 2);
    read_steps(fifo_stat_addr, 0, 1);
    add_step(op_write, adc_low_res_addr, 0, 0, 0, cmp_none);  // leaves fast mode
    add_step(op_read, 8'h40, 0, 0, 0, cmp_lit);
    read_steps(adcread_addr, 0, 2);
    read_steps(fifo_stat_addr, 0, 1);
  endtask

  task automatic run_step(input step_t s);
    logic [7:0] got;
    logic [7:0] exp_byte;
    logic [sample_width-1:0] smp;
    @(negedge clk_usb);
    case (s.op)
      op_write: begin
        {reg_address, reg_bytecnt, reg_datai, reg_write} = {s.addr, s.bytecnt, s.data[7:0], 1'b1};
        @(negedge clk_usb);
        reg_write = 1'b0;  // one idle cycle follows
        predict_write(s.addr, s.bytecnt, s.data[7:0]);
      end
      op_read: begin
        {reg_address, reg_bytecnt, reg_read} = {s.addr, s.bytecnt, 1'b1};
        #2 got = reg_datao;  // settled, pop not before next edge
        predict_read(s.addr, s.bytecnt, exp_byte);
        if (s.cmp == cmp_lit)
          exp_byte = s.expected[7:0];
        if (s.cmp != cmp_none)
          check_value("reg_datao", got, exp_byte);
        @(negedge clk_usb);
        reg_read = 1'b0;
      end
      op_burst: begin
        for (int i = 0; i < s.data; i++) begin
          draw_sample(smp);
          {adc_sample, adc_sample_valid} = {smp, 1'b1};
          pack_sample(smp);
          @(negedge clk_usb);
        end
        adc_sample_valid = 1'b0;
        repeat (2) @(negedge clk_usb);  // last word lands in the fifo
      end
      default: begin
        if (s.cmp != cmp_none)
          check_value("stream_segment_size", stream_segment_size,
                      (s.cmp == cmp_lit) ? s.expected : m_seg);
      end
    endcase
  endtask

  initial begin
    {reset, reg_address, reg_bytecnt, reg_datai} = {1'b1, 8'h00, 7'h00, 8'h00};
    {reg_read, reg_write, adc_sample, adc_sample_valid} = '0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(negedge clk_usb);
    reset = 1'b0;
    for (int i = 0; i < n_steps; i++)
      run_step(steps[i]);
    repeat (4) @(negedge clk_usb);
    $display("errors: %0d check, %0d assertion", errors, u_dut.u_regs.u_assertions.fail_count);
    if (errors == 0 && u_dut.u_regs.u_assertions.fail_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog, 40 cycles per step plus reset
  initial begin
    wait (table_ready);
    #((n_steps * 40 + 10) * 10);
    $display("timeout: step table did not complete in time, %0d errors so far", errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- tb.f
design/reg_map_pkg.sv
design/adc_sample_pkg.sv
design/adc_sample_packer.sv
design/adc_word_fifo.sv
design/reg_adcfifo.sv
design/adc_capture_top.sv
sim/adc_capture_assertions.sv
sim/tb_adc_capture.sv
